// ==== common/csr_pkg.sv ====
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;

    // csr numbers
    localparam csr_addr_t ADDR_CRMD   = 14'h000;
    localparam csr_addr_t ADDR_PRMD   = 14'h001;
    localparam csr_addr_t ADDR_ECFG   = 14'h004;
    localparam csr_addr_t ADDR_ESTAT  = 14'h005;
    localparam csr_addr_t ADDR_ERA    = 14'h006;
    localparam csr_addr_t ADDR_EENTRY = 14'h00c;
    localparam csr_addr_t ADDR_SAVE0  = 14'h030;
    localparam csr_addr_t ADDR_TID    = 14'h040;
    localparam csr_addr_t ADDR_TCFG   = 14'h041;
    localparam csr_addr_t ADDR_TVAL   = 14'h042;
    localparam csr_addr_t ADDR_TICLR  = 14'h044;

    // low bit of each field
    localparam int CRMD_PLV       = 0;
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int CRMD_PG        = 4;
    localparam int CRMD_DATF      = 5;
    localparam int CRMD_DATM      = 7;
    localparam int PRMD_PPLV      = 0;
    localparam int PRMD_PIE       = 2;
    localparam int ESTAT_IS_SW    = 0;
    localparam int ESTAT_IS_HW    = 2;
    localparam int ESTAT_IS_TIMER = 11;
    localparam int ESTAT_ECODE    = 16;
    localparam int ESTAT_ESUBCODE = 22;
    localparam int TCFG_EN        = 0;
    localparam int TCFG_PERIODIC  = 1;
    localparam int TCFG_INITVAL   = 2;
    localparam int TICLR_CLR      = 0;

    localparam int INT_BITS   = 13;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int HW_INT_W   = 8;

    // bits 12:11 and 9:0
    localparam csr_data_t ECFG_MASK   = 32'h0000_1bff;
    localparam csr_data_t CRMD_RESET  = 32'h0000_0008;
    localparam csr_data_t EENTRY_MASK = 32'hffff_ffc0;

endpackage

// ==== rtl/trap_ctrl.sv ====
`timescale 1ns/10ps

module trap_ctrl (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          wr_en,
    input  csr_pkg::csr_addr_t                            waddr,
    input  csr_pkg::csr_data_t                            wdata,
    input  logic                                          excp_flush,
    input  logic                                          ertn_flush,
    input  csr_pkg::csr_data_t                            era_in,
    input  logic [csr_pkg::ECODE_W-1:0]                   ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]                esubcode,
    output csr_pkg::csr_data_t                            crmd,
    output csr_pkg::csr_data_t                            prmd,
    output csr_pkg::csr_data_t                            era,
    output csr_pkg::csr_data_t                            eentry,
    output logic [csr_pkg::ECODE_W+csr_pkg::ESUBCODE_W-1:0] estat_code,
    output logic                                          ie,
    output logic [1:0]                                    plv_out,
    output logic [1:0]                                    dapg,
    output logic [1:0]                                    datf,
    output logic [1:0]                                    datm
);

    logic crmd_wen;
    logic prmd_wen;
    logic era_wen;
    logic eentry_wen;

    assign crmd_wen   = wr_en && (waddr == csr_pkg::ADDR_CRMD);
    assign prmd_wen   = wr_en && (waddr == csr_pkg::ADDR_PRMD);
    assign era_wen    = wr_en && (waddr == csr_pkg::ADDR_ERA);
    assign eentry_wen = wr_en && (waddr == csr_pkg::ADDR_EENTRY);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd       <= csr_pkg::CRMD_RESET;
            prmd       <= '0;
            era        <= '0;
            eentry     <= '0;
            estat_code <= '0;
        end else begin
            // trap entry drops to kernel with interrupts off
            if (excp_flush) begin
                crmd[csr_pkg::CRMD_PLV +: 2]  <= 2'b00;
                crmd[csr_pkg::CRMD_IE]        <= 1'b0;
                prmd[csr_pkg::PRMD_PPLV +: 2] <= crmd[csr_pkg::CRMD_PLV +: 2];
                prmd[csr_pkg::PRMD_PIE]       <= crmd[csr_pkg::CRMD_IE];
                era                           <= era_in;
                estat_code                    <= {esubcode, ecode};
            end else if (ertn_flush) begin
                crmd[csr_pkg::CRMD_PLV +: 2] <= prmd[csr_pkg::PRMD_PPLV +: 2];
                crmd[csr_pkg::CRMD_IE]       <= prmd[csr_pkg::PRMD_PIE];
            end else begin
                if (crmd_wen) begin
                    crmd[csr_pkg::CRMD_PLV +: 2]  <= wdata[csr_pkg::CRMD_PLV +: 2];
                    crmd[csr_pkg::CRMD_IE]        <= wdata[csr_pkg::CRMD_IE];
                    crmd[csr_pkg::CRMD_DA]        <= wdata[csr_pkg::CRMD_DA];
                    crmd[csr_pkg::CRMD_PG]        <= wdata[csr_pkg::CRMD_PG];
                    crmd[csr_pkg::CRMD_DATF +: 2] <= wdata[csr_pkg::CRMD_DATF +: 2];
                    crmd[csr_pkg::CRMD_DATM +: 2] <= wdata[csr_pkg::CRMD_DATM +: 2];
                end
                if (prmd_wen) begin
                    prmd[csr_pkg::PRMD_PPLV +: 2] <= wdata[csr_pkg::PRMD_PPLV +: 2];
                    prmd[csr_pkg::PRMD_PIE]       <= wdata[csr_pkg::PRMD_PIE];
                end
                if (era_wen) begin
                    era <= wdata;
                end
            end
            if (eentry_wen) begin
                eentry <= wdata & csr_pkg::EENTRY_MASK;
            end
        end
    end

    // level seen by fetch after this edge
    always_comb begin
        if (excp_flush) begin
            plv_out = 2'b00;
        end else if (ertn_flush) begin
            plv_out = prmd[csr_pkg::PRMD_PPLV +: 2];
        end else if (crmd_wen) begin
            plv_out = wdata[csr_pkg::CRMD_PLV +: 2];
        end else begin
            plv_out = crmd[csr_pkg::CRMD_PLV +: 2];
        end
    end

    assign ie   = crmd[csr_pkg::CRMD_IE];
    assign dapg = {crmd[csr_pkg::CRMD_DA], crmd[csr_pkg::CRMD_PG]};
    assign datf = crmd[csr_pkg::CRMD_DATF +: 2];
    assign datm = crmd[csr_pkg::CRMD_DATM +: 2];

    a_flush_onehot: assert property (@(posedge clk) disable iff (reset)
        !(excp_flush && ertn_flush))
        else $error("excp_flush and ertn_flush raised in the same cycle");

endmodule

// ==== timer/csr_timer.sv ====
`timescale 1ns/10ps

module csr_timer (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_en,
    input  csr_pkg::csr_addr_t waddr,
    input  csr_pkg::csr_data_t wdata,
    output csr_pkg::csr_data_t tcfg,
    output csr_pkg::csr_data_t tval,
    output logic               timer_int
);

    logic tcfg_wen;
    logic ticlr_wen;
    logic timer_en;
    logic expire;
    csr_pkg::csr_data_t reload;

    assign tcfg_wen  = wr_en && (waddr == csr_pkg::ADDR_TCFG);
    assign ticlr_wen = wr_en && (waddr == csr_pkg::ADDR_TICLR);

    assign reload = {tcfg[31:csr_pkg::TCFG_INITVAL], 2'b00};
    // a tcfg write in the same cycle wins over expiry
    assign expire = timer_en && (tval == '0) && !tcfg_wen;

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg      <= '0;
            tval      <= '0;
            timer_en  <= 1'b0;
            timer_int <= 1'b0;
        end else begin
            if (tcfg_wen) begin
                tcfg     <= wdata;
                tval     <= {wdata[31:csr_pkg::TCFG_INITVAL], 2'b00};
                timer_en <= wdata[csr_pkg::TCFG_EN];
            end else if (expire) begin
                // one-shot parks at all-ones
                tval     <= tcfg[csr_pkg::TCFG_PERIODIC] ? reload : '1;
                timer_en <= tcfg[csr_pkg::TCFG_PERIODIC];
            end else if (timer_en) begin
                tval <= tval - 32'd1;
            end

            if (ticlr_wen && wdata[csr_pkg::TICLR_CLR]) begin
                timer_int <= 1'b0;
            end else if (expire) begin
                timer_int <= 1'b1;
            end
        end
    end

    a_tval_hold: assert property (@(posedge clk) disable iff (reset)
        (!timer_en && !tcfg_wen) |=> $stable(tval))
        else $error("tval changed while the timer was disabled");

endmodule

// ==== rtl/intr_ctrl.sv ====
`timescale 1ns/10ps

module intr_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  csr_pkg::csr_addr_t            waddr,
    input  csr_pkg::csr_data_t            wdata,
    input  logic [csr_pkg::HW_INT_W-1:0]  hw_int,
    input  logic                          timer_int,
    input  logic                          ie,
    output csr_pkg::csr_data_t            ecfg,
    output logic [csr_pkg::INT_BITS-1:0]  estat_is,
    output logic                          has_int
);

    logic ecfg_wen;
    logic estat_wen;
    logic [1:0] sw_int;
    logic [csr_pkg::HW_INT_W-1:0] hw_q;

    assign ecfg_wen  = wr_en && (waddr == csr_pkg::ADDR_ECFG);
    assign estat_wen = wr_en && (waddr == csr_pkg::ADDR_ESTAT);

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg   <= '0;
            sw_int <= '0;
            hw_q   <= '0;
        end else begin
            if (ecfg_wen) begin
                ecfg <= wdata & csr_pkg::ECFG_MASK;
            end
            // only the two software bits of estat are writable
            if (estat_wen) begin
                sw_int <= wdata[csr_pkg::ESTAT_IS_SW +: 2];
            end
            hw_q <= hw_int;
        end
    end

    always_comb begin
        estat_is = '0;
        estat_is[csr_pkg::ESTAT_IS_SW +: 2] = sw_int;
        estat_is[csr_pkg::ESTAT_IS_HW +: csr_pkg::HW_INT_W] = hw_q;
        estat_is[csr_pkg::ESTAT_IS_TIMER] = timer_int;
    end

    assign has_int = (|(estat_is & ecfg[csr_pkg::INT_BITS-1:0])) && ie;

endmodule

// ==== rtl/scratch_regs.sv ====
`timescale 1ns/10ps

module scratch_regs #(
    parameter int NUM_SAVE = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_en,
    input  csr_pkg::csr_addr_t waddr,
    input  csr_pkg::csr_data_t wdata,
    output csr_pkg::csr_data_t save [NUM_SAVE],
    output csr_pkg::csr_data_t tid
);

    csr_pkg::csr_addr_t save_off;
    logic tid_wen;

    // below ADDR_SAVE0 this wraps high and matches no index
    assign save_off = waddr - csr_pkg::ADDR_SAVE0;
    assign tid_wen  = wr_en && (waddr == csr_pkg::ADDR_TID);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_SAVE; i++) begin
                save[i] <= '0;
            end
            tid <= '0;
        end else begin
            for (int i = 0; i < NUM_SAVE; i++) begin
                if (wr_en && (save_off == csr_pkg::csr_addr_t'(i))) begin
                    save[i] <= wdata;
                end
            end
            if (tid_wen) begin
                tid <= wdata;
            end
        end
    end

endmodule

// ==== rtl/csr_read_mux.sv ====
`timescale 1ns/10ps

module csr_read_mux #(
    parameter int NUM_SAVE = 4
) (
    input  csr_pkg::csr_addr_t                            raddr,
    input  logic                                          wr_en,
    input  csr_pkg::csr_addr_t                            waddr,
    input  csr_pkg::csr_data_t                            wdata,
    input  csr_pkg::csr_data_t                            crmd,
    input  csr_pkg::csr_data_t                            prmd,
    input  csr_pkg::csr_data_t                            era,
    input  csr_pkg::csr_data_t                            eentry,
    input  csr_pkg::csr_data_t                            ecfg,
    input  csr_pkg::csr_data_t                            tcfg,
    input  csr_pkg::csr_data_t                            tval,
    input  csr_pkg::csr_data_t                            tid,
    input  csr_pkg::csr_data_t                            save [NUM_SAVE],
    input  logic [csr_pkg::ECODE_W+csr_pkg::ESUBCODE_W-1:0] estat_code,
    input  logic [csr_pkg::INT_BITS-1:0]                  estat_is,
    output csr_pkg::csr_data_t                            rdata
);

    csr_pkg::csr_data_t estat;
    csr_pkg::csr_data_t reg_data;
    csr_pkg::csr_addr_t save_roff;

    // estat_code packs the subcode above the code
    always_comb begin
        estat = '0;
        estat[csr_pkg::INT_BITS-1:0] = estat_is;
        estat[csr_pkg::ESTAT_ECODE +: csr_pkg::ECODE_W] = estat_code[csr_pkg::ECODE_W-1:0];
        estat[csr_pkg::ESTAT_ESUBCODE +: csr_pkg::ESUBCODE_W] =
            estat_code[csr_pkg::ECODE_W +: csr_pkg::ESUBCODE_W];
    end

    assign save_roff = raddr - csr_pkg::ADDR_SAVE0;

    always_comb begin
        reg_data = '0;
        case (raddr)
            csr_pkg::ADDR_CRMD:   reg_data = crmd;
            csr_pkg::ADDR_PRMD:   reg_data = prmd;
            csr_pkg::ADDR_ECFG:   reg_data = ecfg;
            csr_pkg::ADDR_ESTAT:  reg_data = estat;
            csr_pkg::ADDR_ERA:    reg_data = era;
            csr_pkg::ADDR_EENTRY: reg_data = eentry;
            csr_pkg::ADDR_TID:    reg_data = tid;
            csr_pkg::ADDR_TCFG:   reg_data = tcfg;
            csr_pkg::ADDR_TVAL:   reg_data = tval;
            default:              reg_data = '0;
        endcase
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (save_roff == csr_pkg::csr_addr_t'(i)) begin
                reg_data = save[i];
            end
        end
    end

    // forward a write landing on the read address this cycle
    assign rdata = (wr_en && (waddr == raddr)) ? wdata : reg_data;

endmodule

// ==== rtl/csr_unit.sv ====
`timescale 1ns/10ps

module csr_unit #(
    parameter int NUM_SAVE = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wr_en,
    input  csr_pkg::csr_addr_t                 waddr,
    input  csr_pkg::csr_data_t                 wdata,
    input  csr_pkg::csr_addr_t                 raddr,
    output csr_pkg::csr_data_t                 rdata,
    input  logic                               excp_flush,
    input  logic                               ertn_flush,
    input  csr_pkg::csr_data_t                 era_in,
    input  logic [csr_pkg::ECODE_W-1:0]        ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]     esubcode,
    input  logic [csr_pkg::HW_INT_W-1:0]       hw_int,
    output logic                               has_int,
    output logic [1:0]                         plv_out,
    output csr_pkg::csr_data_t                 eentry_out,
    output csr_pkg::csr_data_t                 era_out,
    output logic [1:0]                         dapg,
    output logic [1:0]                         datf,
    output logic [1:0]                         datm
);

    csr_pkg::csr_data_t crmd;
    csr_pkg::csr_data_t prmd;
    csr_pkg::csr_data_t ecfg;
    csr_pkg::csr_data_t tcfg;
    csr_pkg::csr_data_t tval;
    csr_pkg::csr_data_t tid;
    csr_pkg::csr_data_t save [NUM_SAVE];
    logic [csr_pkg::ECODE_W+csr_pkg::ESUBCODE_W-1:0] estat_code;
    logic [csr_pkg::INT_BITS-1:0] estat_is;
    logic ie;
    logic timer_int;

    trap_ctrl u_trap (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .waddr      (waddr),
        .wdata      (wdata),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .era_in     (era_in),
        .ecode      (ecode),
        .esubcode   (esubcode),
        .crmd       (crmd),
        .prmd       (prmd),
        .era        (era_out),
        .eentry     (eentry_out),
        .estat_code (estat_code),
        .ie         (ie),
        .plv_out    (plv_out),
        .dapg       (dapg),
        .datf       (datf),
        .datm       (datm)
    );

    intr_ctrl u_intr (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .waddr     (waddr),
        .wdata     (wdata),
        .hw_int    (hw_int),
        .timer_int (timer_int),
        .ie        (ie),
        .ecfg      (ecfg),
        .estat_is  (estat_is),
        .has_int   (has_int)
    );

    csr_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .waddr     (waddr),
        .wdata     (wdata),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    scratch_regs #(.NUM_SAVE(NUM_SAVE)) u_scratch (
        .clk   (clk),
        .reset (reset),
        .wr_en (wr_en),
        .waddr (waddr),
        .wdata (wdata),
        .save  (save),
        .tid   (tid)
    );

    csr_read_mux #(.NUM_SAVE(NUM_SAVE)) u_rmux (
        .raddr      (raddr),
        .wr_en      (wr_en),
        .waddr      (waddr),
        .wdata      (wdata),
        .crmd       (crmd),
        .prmd       (prmd),
        .era        (era_out),
        .eentry     (eentry_out),
        .ecfg       (ecfg),
        .tcfg       (tcfg),
        .tval       (tval),
        .tid        (tid),
        .save       (save),
        .estat_code (estat_code),
        .estat_is   (estat_is),
        .rdata      (rdata)
    );

endmodule

// ==== dv/csr_tests.svh ====
`ifndef CSR_TESTS_SVH
`define CSR_TESTS_SVH

task automatic csr_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data);
    @(posedge clk);
    wr_en <= 1'b1;
    waddr <= addr;
    wdata <= data;
    @(posedge clk);
    wr_en <= 1'b0;
endtask

// rdata is combinational, settled by the falling edge
task automatic csr_read(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_data_t data);
    @(posedge clk);
    raddr <= addr;
    @(negedge clk);
    data = rdata;
endtask

task automatic compare_value(input string name, input csr_pkg::csr_data_t expected,
                             input csr_pkg::csr_data_t actual);
    checks++;
    assert (actual === expected)
    else begin
        value_errors++;
        $display("[ERROR] %0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
    end
endtask

task automatic at_most(input string name, input csr_pkg::csr_data_t limit,
                       input csr_pkg::csr_data_t actual);
    checks++;
    assert (actual <= limit)
    else begin
        value_errors++;
        $display("[ERROR] %0t %s expected at most 0x%08h got 0x%08h",
                 $time, name, limit, actual);
    end
endtask

task automatic read_expect(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t expected,
                           input string name);
    csr_pkg::csr_data_t data;
    csr_read(addr, data);
    compare_value(name, expected, data);
endtask

// counts edges from the call, raddr already on ESTAT
task automatic wait_timer_bit(input int limit, output int edges);
    edges = 0;
    @(negedge clk);
    while (!rdata[csr_pkg::ESTAT_IS_TIMER] && edges < limit) begin
        @(posedge clk);
        edges++;
        @(negedge clk);
    end
    if (!rdata[csr_pkg::ESTAT_IS_TIMER]) begin
        timeouts++;
        $display("timeout at %0t: the timer bit did not set within %0d cycles", $time, limit);
    end
endtask

task automatic reset_and_scratch();
    csr_pkg::csr_data_t words [5];
    csr_pkg::csr_data_t fresh;
    csr_pkg::csr_addr_t addr;
    int i;
    @(negedge clk);
    compare_value("has_int", 32'd0, 32'(has_int));
    compare_value("plv_out", 32'd0, 32'(plv_out));
    compare_value("dapg", 32'd2, 32'(dapg));
    read_expect(csr_pkg::ADDR_CRMD, 32'h0000_0008, "crmd");
    read_expect(csr_pkg::ADDR_PRMD, 32'd0, "prmd");
    read_expect(csr_pkg::ADDR_ECFG, 32'd0, "ecfg");
    read_expect(csr_pkg::ADDR_ESTAT, 32'd0, "estat");
    read_expect(csr_pkg::ADDR_ERA, 32'd0, "era");
    read_expect(csr_pkg::ADDR_EENTRY, 32'd0, "eentry");
    read_expect(csr_pkg::ADDR_TID, 32'd0, "tid");
    read_expect(csr_pkg::ADDR_TCFG, 32'd0, "tcfg");
    read_expect(csr_pkg::ADDR_TVAL, 32'd0, "tval");
    read_expect(csr_pkg::ADDR_TICLR, 32'd0, "ticlr");
    for (i = 0; i < 4; i++) begin
        addr = csr_pkg::csr_addr_t'(csr_pkg::ADDR_SAVE0 + i);
        read_expect(addr, 32'd0, $sformatf("save%0d", i));
    end
    for (i = 0; i < 5; i++) begin
        words[i] = $urandom;
    end
    for (i = 0; i < 4; i++) begin
        csr_write(csr_pkg::csr_addr_t'(csr_pkg::ADDR_SAVE0 + i), words[i]);
    end
    csr_write(csr_pkg::ADDR_TID, words[4]);
    for (i = 0; i < 4; i++) begin
        addr = csr_pkg::csr_addr_t'(csr_pkg::ADDR_SAVE0 + i);
        read_expect(addr, words[i], $sformatf("save%0d", i));
    end
    read_expect(csr_pkg::ADDR_TID, words[4], "tid");

    // write and read the same address in one cycle
    fresh = ~words[1];
    addr = csr_pkg::csr_addr_t'(csr_pkg::ADDR_SAVE0 + 1);
    @(posedge clk);
    wr_en <= 1'b1;
    waddr <= addr;
    wdata <= fresh;
    raddr <= addr;
    @(negedge clk);
    compare_value("rdata", fresh, rdata);
    @(posedge clk);
    wr_en <= 1'b0;
    read_expect(addr, fresh, "save1");
endtask

task automatic write_masking();
    csr_pkg::csr_data_t w;
    int i;
    for (i = 0; i < 4; i++) begin
        w = $urandom;
        csr_write(csr_pkg::ADDR_CRMD, w);
        @(negedge clk);
        compare_value("dapg", 32'({w[3], w[4]}), 32'(dapg));
        compare_value("datf", 32'(w[6:5]), 32'(datf));
        compare_value("datm", 32'(w[8:7]), 32'(datm));
        compare_value("plv_out", 32'(w[1:0]), 32'(plv_out));
        read_expect(csr_pkg::ADDR_CRMD, w & 32'h0000_01ff, "crmd");
        // ecfg keeps bits 12:11 and 9:0
        w = $urandom;
        csr_write(csr_pkg::ADDR_ECFG, w);
        read_expect(csr_pkg::ADDR_ECFG, w & 32'h0000_1bff, "ecfg");
        w = $urandom;
        csr_write(csr_pkg::ADDR_EENTRY, w);
        read_expect(csr_pkg::ADDR_EENTRY, w & 32'hffff_ffc0, "eentry");
        compare_value("eentry_out", w & 32'hffff_ffc0, eentry_out);
    end
    csr_write(csr_pkg::ADDR_CRMD, 32'h0000_0008);
    csr_write(csr_pkg::ADDR_ECFG, 32'd0);
endtask

task automatic trap_entry_return();
    csr_pkg::csr_data_t era_val;
    csr_pkg::csr_data_t d;
    logic [5:0] code;
    logic [8:0] subcode;
    era_val = $urandom;
    code    = 6'($urandom);
    subcode = 9'($urandom);
    // plv 3 with ie set
    csr_write(csr_pkg::ADDR_CRMD, 32'h0000_000f);
    @(posedge clk);
    excp_flush <= 1'b1;
    era_in     <= era_val;
    ecode      <= code;
    esubcode   <= subcode;
    @(negedge clk);
    compare_value("plv_out", 32'd0, 32'(plv_out));
    @(posedge clk);
    excp_flush <= 1'b0;
    read_expect(csr_pkg::ADDR_CRMD, 32'h0000_0008, "crmd");
    read_expect(csr_pkg::ADDR_PRMD, 32'h0000_0007, "prmd");
    read_expect(csr_pkg::ADDR_ERA, era_val, "era");
    compare_value("era_out", era_val, era_out);
    csr_read(csr_pkg::ADDR_ESTAT, d);
    compare_value("estat.ecode", 32'(code), 32'(d[21:16]));
    compare_value("estat.esubcode", 32'(subcode), 32'(d[30:22]));
    @(posedge clk);
    ertn_flush <= 1'b1;
    @(negedge clk);
    compare_value("plv_out", 32'd3, 32'(plv_out));
    @(posedge clk);
    ertn_flush <= 1'b0;
    read_expect(csr_pkg::ADDR_CRMD, 32'h0000_000f, "crmd");
    csr_write(csr_pkg::ADDR_CRMD, 32'h0000_0008);
endtask

task automatic oneshot_timer();
    csr_pkg::csr_data_t d;
    csr_pkg::csr_data_t cfg;
    int n;
    int edges;
    n = 4 + int'($urandom % 9);
    cfg = csr_pkg::csr_data_t'(n << 2) | 32'h1;
    csr_read(csr_pkg::ADDR_ESTAT, d);
    compare_value("estat.ti", 32'd0, 32'(d[11]));
    csr_write(csr_pkg::ADDR_TCFG, cfg);
    wait_timer_bit(4 * n + 20, edges);
    compare_value("timer_int edges", 32'(4 * n + 1), 32'(edges));
    read_expect(csr_pkg::ADDR_TVAL, 32'hffff_ffff, "tval");
    repeat (5) @(posedge clk);
    read_expect(csr_pkg::ADDR_TVAL, 32'hffff_ffff, "tval");
    read_expect(csr_pkg::ADDR_TCFG, cfg, "tcfg");
    csr_write(csr_pkg::ADDR_TICLR, 32'h1);
    csr_read(csr_pkg::ADDR_ESTAT, d);
    compare_value("estat.ti", 32'd0, 32'(d[11]));
    read_expect(csr_pkg::ADDR_TICLR, 32'd0, "ticlr");
endtask

task automatic periodic_timer();
    csr_pkg::csr_data_t d;
    int n;
    int edges;
    int round;
    int k;
    n = 4 + int'($urandom % 4);
    csr_write(csr_pkg::ADDR_TCFG, csr_pkg::csr_data_t'(n << 2) | 32'h3);
    for (round = 0; round < 3; round++) begin
        csr_read(csr_pkg::ADDR_ESTAT, d);
        // a clear that lands on an expiry costs one extra period
        wait_timer_bit(2 * (4 * n + 1) + 8, edges);
        for (k = 0; k < 3; k++) begin
            csr_read(csr_pkg::ADDR_TVAL, d);
            at_most("tval", csr_pkg::csr_data_t'(n << 2), d);
        end
        csr_write(csr_pkg::ADDR_TICLR, 32'h1);
        csr_read(csr_pkg::ADDR_ESTAT, d);
        compare_value("estat.ti", 32'd0, 32'(d[11]));
    end
    csr_write(csr_pkg::ADDR_TCFG, 32'd0);
endtask

task automatic gating_sweep(input logic [12:0] pending);
    csr_pkg::csr_data_t en;
    logic ie_bit;
    logic expected;
    int t;
    for (t = 0; t < 6; t++) begin
        case (t)
            0: begin
                en = 32'h0000_1bff;
                ie_bit = 1'b1;
            end
            1: begin
                en = 32'h0000_1bff;
                ie_bit = 1'b0;
            end
            2: begin
                en = 32'd0;
                ie_bit = 1'b1;
            end
            default: begin
                en = $urandom & 32'h0000_1bff;
                ie_bit = 1'($urandom);
            end
        endcase
        csr_write(csr_pkg::ADDR_ECFG, en);
        csr_write(csr_pkg::ADDR_CRMD, 32'h0000_0008 | {29'd0, ie_bit, 2'b00});
        @(negedge clk);
        expected = (|(pending & en[12:0])) && ie_bit;
        compare_value("has_int", 32'(expected), 32'(has_int));
    end
endtask

task automatic interrupt_gating();
    csr_pkg::csr_data_t d;
    logic [7:0] lines;
    logic [1:0] sw;
    int edges;
    lines = 8'($urandom) | 8'h01;
    @(posedge clk);
    hw_int <= lines;
    csr_write(csr_pkg::ADDR_ESTAT, 32'd0);
    csr_read(csr_pkg::ADDR_ESTAT, d);
    compare_value("estat.is", 32'({3'b000, lines, 2'b00}), 32'(d[12:0]));
    gating_sweep({3'b000, lines, 2'b00});

    sw = 2'($urandom) | 2'b01;
    @(posedge clk);
    hw_int <= '0;
    csr_write(csr_pkg::ADDR_ESTAT, 32'(sw));
    csr_read(csr_pkg::ADDR_ESTAT, d);
    compare_value("estat.is", 32'(sw), 32'(d[12:0]));
    gating_sweep({11'd0, sw});

    // one-shot with initval 2 as the only source
    csr_write(csr_pkg::ADDR_ESTAT, 32'd0);
    csr_read(csr_pkg::ADDR_ESTAT, d);
    csr_write(csr_pkg::ADDR_TCFG, 32'h0000_0009);
    wait_timer_bit(30, edges);
    gating_sweep(13'h0800);
    csr_write(csr_pkg::ADDR_TICLR, 32'h1);
    csr_write(csr_pkg::ADDR_ECFG, 32'd0);
    csr_write(csr_pkg::ADDR_CRMD, 32'h0000_0008);
endtask

`endif

// ==== dv/tb_csr_unit.sv ====
`timescale 1ns/10ps

module tb_csr_unit;

    logic clk;
    logic reset;
    logic wr_en;
    csr_pkg::csr_addr_t waddr;
    csr_pkg::csr_data_t wdata;
    csr_pkg::csr_addr_t raddr;
    csr_pkg::csr_data_t rdata;
    logic excp_flush;
    logic ertn_flush;
    csr_pkg::csr_data_t era_in;
    logic [csr_pkg::ECODE_W-1:0] ecode;
    logic [csr_pkg::ESUBCODE_W-1:0] esubcode;
    logic [csr_pkg::HW_INT_W-1:0] hw_int;
    logic has_int;
    logic [1:0] plv_out;
    csr_pkg::csr_data_t eentry_out;
    csr_pkg::csr_data_t era_out;
    logic [1:0] dapg;
    logic [1:0] datf;
    logic [1:0] datm;

    int checks;
    int value_errors;
    int timeouts;

    csr_unit #(.NUM_SAVE(4)) uut (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .waddr      (waddr),
        .wdata      (wdata),
        .raddr      (raddr),
        .rdata      (rdata),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .era_in     (era_in),
        .ecode      (ecode),
        .esubcode   (esubcode),
        .hw_int     (hw_int),
        .has_int    (has_int),
        .plv_out    (plv_out),
        .eentry_out (eentry_out),
        .era_out    (era_out),
        .dapg       (dapg),
        .datf       (datf),
        .datm       (datm)
    );

    `include "csr_tests.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset        = 1'b1;
        wr_en        = 1'b0;
        waddr        = '0;
        wdata        = '0;
        raddr        = '0;
        excp_flush   = 1'b0;
        ertn_flush   = 1'b0;
        era_in       = '0;
        ecode        = '0;
        esubcode     = '0;
        hw_int       = '0;
        checks       = 0;
        value_errors = 0;
        timeouts     = 0;
        void'($urandom(72097));

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        reset_and_scratch();
        write_masking();
        trap_entry_return();
        oneshot_timer();
        periodic_timer();
        interrupt_gating();

        $display("checks %0d, value errors %0d, timeouts %0d", checks, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+dv
common/csr_pkg.sv
rtl/trap_ctrl.sv
timer/csr_timer.sv
rtl/intr_ctrl.sv
rtl/scratch_regs.sv
rtl/csr_read_mux.sv
rtl/csr_unit.sv
dv/tb_csr_unit.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_csr_unit
FILELIST = verilog.f
OBJ_DIR  = obj_dir
PASS     = TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
